// ==== design/execute_unit.sv ====
module execute_unit (
  input  logic                                    clock,
  input  logic                                    reset,
  input  logic                                    dispatch_en,
  input  ooo_pkg::issue_t [ooo_pkg::num_super-1:0] issue,
  output ooo_pkg::cdb_t   [ooo_pkg::num_super-1:0] cdb
);

  ooo_pkg::issue_t [ooo_pkg::num_super-1:0] stage1;

  function automatic logic [ooo_pkg::data_w-1:0] alu(
    input ooo_pkg::opcode_e          op,
    input logic [ooo_pkg::opnd_w-1:0] src_a,
    input logic [ooo_pkg::opnd_w-1:0] src_b
  );
    logic [ooo_pkg::data_w-1:0] a;
    logic [ooo_pkg::data_w-1:0] b;
    a = {{(ooo_pkg::data_w - ooo_pkg::opnd_w){1'b0}}, src_a};
    b = {{(ooo_pkg::data_w - ooo_pkg::opnd_w){1'b0}}, src_b};
    case (op)
      ooo_pkg::op_add: alu = a + b;
      ooo_pkg::op_sub: alu = a - b;
      ooo_pkg::op_xor: alu = a ^ b;
      // branches carry no value
      default:         alu = '0;
    endcase
  endfunction

  // operand latch
  always_ff @(posedge clock) begin
    for (int l = 0; l < ooo_pkg::num_super; l++) begin
      stage1[l]       <= issue[l];
      stage1[l].valid <= dispatch_en && issue[l].valid;
      if (reset) stage1[l].valid <= 1'b0;
    end
  end

  // compute and drive the bus
  always_ff @(posedge clock) begin
    for (int l = 0; l < ooo_pkg::num_super; l++) begin
      cdb[l].valid      <= stage1[l].valid;
      cdb[l].rob_idx    <= stage1[l].rob_idx;
      cdb[l].t_idx      <= stage1[l].t_idx;
      cdb[l].writes_reg <= stage1[l].writes_reg;
      cdb[l].value      <= alu(stage1[l].op, stage1[l].src_a, stage1[l].src_b);
      cdb[l].mispredict <= (stage1[l].op == ooo_pkg::op_branch_miss);
      if (reset) cdb[l].valid <= 1'b0;
    end
  end

endmodule

// ==== design/inst_decoder.sv ====
module inst_decoder (
  input  logic [ooo_pkg::num_super-1:0][ooo_pkg::inst_w-1:0] inst,
  output ooo_pkg::decoded_t [ooo_pkg::num_super-1:0]          dec
);

  always_comb begin
    for (int l = 0; l < ooo_pkg::num_super; l++) begin
      // fields
      dec[l].op    = ooo_pkg::opcode_e'(inst[l][15:13]);
      dec[l].dest  = inst[l][12:10];
      dec[l].src_a = inst[l][9:5];
      dec[l].src_b = inst[l][4:0];

      // flags from the opcode
      dec[l].writes_reg = 1'b0;
      dec[l].is_branch  = 1'b0;
      dec[l].halt       = 1'b0;
      dec[l].illegal    = 1'b0;
      case (dec[l].op)
        ooo_pkg::op_add, ooo_pkg::op_sub, ooo_pkg::op_xor: begin
          dec[l].writes_reg = 1'b1;
        end
        ooo_pkg::op_branch, ooo_pkg::op_branch_miss: begin
          dec[l].is_branch = 1'b1;
        end
        ooo_pkg::op_halt: begin
          dec[l].halt = 1'b1;
        end
        default: begin
          // two spare encodings
          dec[l].illegal = 1'b1;
        end
      endcase
    end
  end

endmodule

// ==== design/ooo_core.sv ====
module ooo_core (
  input  logic                                               clock,
  input  logic                                               reset,
  input  logic                                               inst_valid,
  input  logic [ooo_pkg::num_super-1:0][ooo_pkg::inst_w-1:0] inst,
  output logic                                               dispatch_ready,
  output ooo_pkg::retire_out_t [ooo_pkg::num_super-1:0]      retire_out
);

  ooo_pkg::decoded_t [ooo_pkg::num_super-1:0]    dec;
  ooo_pkg::rename_t  [ooo_pkg::num_super-1:0]    ren;
  ooo_pkg::issue_t   [ooo_pkg::num_super-1:0]    issue;
  ooo_pkg::cdb_t     [ooo_pkg::num_super-1:0]    cdb;
  ooo_pkg::retire_t  [ooo_pkg::num_super-1:0]    retire;
  logic [ooo_pkg::num_super-1:0][ooo_pkg::rob_w-1:0] rob_idx;
  logic rob_ready;
  logic rename_ready;
  logic stopped;
  logic restore;
  logic dispatch_en;

  assign dispatch_ready = rob_ready && rename_ready && !stopped;
  assign dispatch_en    = inst_valid && dispatch_ready;

  // halt and illegal lanes go to the ROB only
  always_comb begin
    for (int l = 0; l < ooo_pkg::num_super; l++) begin
      issue[l].valid      = !(dec[l].halt || dec[l].illegal);
      issue[l].op         = dec[l].op;
      issue[l].src_a      = dec[l].src_a;
      issue[l].src_b      = dec[l].src_b;
      issue[l].writes_reg = dec[l].writes_reg;
      issue[l].t_idx      = ren[l].t_idx;
      issue[l].rob_idx    = rob_idx[l];
    end
  end

  inst_decoder i_decoder (
    .inst (inst),
    .dec  (dec)
  );

  rename_unit i_rename (
    .clock        (clock),
    .reset        (reset),
    .dispatch_en  (dispatch_en),
    .dec          (dec),
    .retire       (retire),
    .restore      (restore),
    .ren          (ren),
    .rename_ready (rename_ready)
  );

  execute_unit i_execute (
    .clock       (clock),
    .reset       (reset),
    .dispatch_en (dispatch_en),
    .issue       (issue),
    .cdb         (cdb)
  );

  reorder_buffer i_rob (
    .clock       (clock),
    .reset       (reset),
    .dispatch_en (dispatch_en),
    .dec         (dec),
    .ren         (ren),
    .cdb         (cdb),
    .rob_idx     (rob_idx),
    .rob_ready   (rob_ready),
    .stopped     (stopped),
    .restore     (restore),
    .retire      (retire)
  );

  result_regfile i_regfile (
    .clock      (clock),
    .reset      (reset),
    .cdb        (cdb),
    .retire     (retire),
    .retire_out (retire_out)
  );

endmodule

// ==== design/ooo_pkg.sv ====
package ooo_pkg;

  localparam int num_super = 2;
  localparam int num_arch = 8;
  localparam int num_phys = 16;
  localparam int num_rob = 8;
  localparam int arch_w = 3;
  localparam int phys_w = 4;
  localparam int rob_w = 3;
  localparam int data_w = 8;
  localparam int opnd_w = 5;
  localparam int inst_w = 16;

  // top three bits of every instruction word
  typedef enum logic [2:0] {
    op_add,
    op_sub,
    op_xor,
    op_branch,
    op_branch_miss,
    op_halt,
    op_illegal_a,
    op_illegal_b
  } opcode_e;

  typedef struct packed {
    opcode_e             op;
    logic [arch_w-1:0]   dest;
    logic [opnd_w-1:0]   src_a;
    logic [opnd_w-1:0]   src_b;
    logic                writes_reg;
    logic                is_branch;
    logic                halt;
    logic                illegal;
  } decoded_t;

  typedef struct packed {
    logic [phys_w-1:0]   t_idx;
    logic [phys_w-1:0]   told_idx;
    logic [arch_w-1:0]   dest;
  } rename_t;

  typedef struct packed {
    logic                valid;
    opcode_e             op;
    logic [opnd_w-1:0]   src_a;
    logic [opnd_w-1:0]   src_b;
    logic                writes_reg;
    logic [phys_w-1:0]   t_idx;
    logic [rob_w-1:0]    rob_idx;
  } issue_t;

  typedef struct packed {
    logic                valid;
    logic [rob_w-1:0]    rob_idx;
    logic [phys_w-1:0]   t_idx;
    logic                writes_reg;
    logic [data_w-1:0]   value;
    logic                mispredict;
  } cdb_t;

  typedef struct packed {
    logic                valid;
    logic [arch_w-1:0]   dest;
    logic [phys_w-1:0]   t_idx;
    logic [phys_w-1:0]   told_idx;
    logic                writes_reg;
    logic                halt;
    logic                illegal;
  } retire_t;

  // one retire lane as seen from outside the core
  typedef struct packed {
    logic                valid;
    logic [arch_w-1:0]   dest;
    logic [data_w-1:0]   value;
    logic                writes_reg;
    logic                halt;
    logic                illegal;
  } retire_out_t;

endpackage

// ==== design/rename_unit.sv ====
module rename_unit (
  input  logic                                      clock,
  input  logic                                      reset,
  input  logic                                      dispatch_en,
  input  ooo_pkg::decoded_t [ooo_pkg::num_super-1:0] dec,
  input  ooo_pkg::retire_t  [ooo_pkg::num_super-1:0] retire,
  input  logic                                      restore,
  output ooo_pkg::rename_t  [ooo_pkg::num_super-1:0] ren,
  output logic                                      rename_ready
);

  logic [ooo_pkg::phys_w-1:0]   spec_map [ooo_pkg::num_arch];
  logic [ooo_pkg::phys_w-1:0]   arch_map [ooo_pkg::num_arch];
  logic [ooo_pkg::num_phys-1:0] free_list;
  logic [ooo_pkg::num_phys-1:0] arch_used;
  logic [ooo_pkg::phys_w-1:0]   first_free;
  logic [ooo_pkg::phys_w-1:0]   second_free;
  logic                         found_first;
  logic                         found_second;

  // two lowest free tags
  always_comb begin
    found_first  = 1'b0;
    found_second = 1'b0;
    first_free   = '0;
    second_free  = '0;
    for (int i = 0; i < ooo_pkg::num_phys; i++) begin
      if (free_list[i]) begin
        if (!found_first) begin
          first_free  = i[ooo_pkg::phys_w-1:0];
          found_first = 1'b1;
        end else if (!found_second) begin
          second_free  = i[ooo_pkg::phys_w-1:0];
          found_second = 1'b1;
        end
      end
    end
  end

  assign rename_ready = found_second;

  always_comb begin
    ren[0].dest     = dec[0].dest;
    ren[0].t_idx    = dec[0].writes_reg ? first_free : '0;
    ren[0].told_idx = dec[0].writes_reg ? spec_map[dec[0].dest] : '0;

    // lane 1 sees lane 0's mapping when both write the same register
    ren[1].dest     = dec[1].dest;
    ren[1].t_idx    = '0;
    ren[1].told_idx = '0;
    if (dec[1].writes_reg) begin
      ren[1].t_idx = dec[0].writes_reg ? second_free : first_free;
      if (dec[0].writes_reg && dec[0].dest == dec[1].dest) begin
        ren[1].told_idx = ren[0].t_idx;
      end else begin
        ren[1].told_idx = spec_map[dec[1].dest];
      end
    end
  end

  // tags still held by committed state
  always_comb begin
    arch_used = '0;
    for (int i = 0; i < ooo_pkg::num_arch; i++) begin
      arch_used[arch_map[i]] = 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < ooo_pkg::num_arch; i++) begin
        spec_map[i] <= i[ooo_pkg::phys_w-1:0];
        arch_map[i] <= i[ooo_pkg::phys_w-1:0];
      end
      for (int i = 0; i < ooo_pkg::num_phys; i++) begin
        free_list[i] <= (i >= ooo_pkg::num_arch);
      end
    end else if (restore) begin
      for (int i = 0; i < ooo_pkg::num_arch; i++) begin
        spec_map[i] <= arch_map[i];
      end
      free_list <= ~arch_used;
    end else begin
      for (int l = 0; l < ooo_pkg::num_super; l++) begin
        if (retire[l].valid && retire[l].writes_reg) begin
          arch_map[retire[l].dest]   <= retire[l].t_idx;
          free_list[retire[l].told_idx] <= 1'b1;
        end
      end
      if (dispatch_en) begin
        for (int l = 0; l < ooo_pkg::num_super; l++) begin
          if (dec[l].writes_reg) begin
            spec_map[dec[l].dest]  <= ren[l].t_idx;
            free_list[ren[l].t_idx] <= 1'b0;
          end
        end
      end
    end
  end

  for (genvar l = 0; l < ooo_pkg::num_super; l++) begin : g_free_chk
    a_no_double_free: assert property (@(posedge clock) disable iff (reset)
      retire[l].valid && retire[l].writes_reg |-> !free_list[retire[l].told_idx]);
  end

endmodule

// ==== design/reorder_buffer.sv ====
module reorder_buffer (
  input  logic                                          clock,
  input  logic                                          reset,
  input  logic                                          dispatch_en,
  input  ooo_pkg::decoded_t [ooo_pkg::num_super-1:0]     dec,
  input  ooo_pkg::rename_t  [ooo_pkg::num_super-1:0]     ren,
  input  ooo_pkg::cdb_t     [ooo_pkg::num_super-1:0]     cdb,
  output logic [ooo_pkg::num_super-1:0][ooo_pkg::rob_w-1:0] rob_idx,
  output logic                                          rob_ready,
  output logic                                          stopped,
  output logic                                          restore,
  output ooo_pkg::retire_t  [ooo_pkg::num_super-1:0]     retire
);

  typedef struct packed {
    logic                       valid;
    logic                       complete;
    logic                       halt;
    logic                       illegal;
    logic                       writes_reg;
    logic [ooo_pkg::arch_w-1:0] dest;
    logic [ooo_pkg::phys_w-1:0] t_idx;
    logic [ooo_pkg::phys_w-1:0] told_idx;
  } rob_entry_t;

  rob_entry_t                   entries [ooo_pkg::num_rob];
  logic [ooo_pkg::rob_w-1:0]    head;
  logic [ooo_pkg::rob_w-1:0]    tail;
  logic [ooo_pkg::rob_w:0]      count;
  logic [ooo_pkg::rob_w-1:0]    ret_ptr [ooo_pkg::num_super];
  logic [ooo_pkg::num_super-1:0] retire_en;
  logic [ooo_pkg::rob_w:0]      n_retire;
  logic [ooo_pkg::rob_w:0]      n_dispatch;
  logic                         rb_en;
  logic [ooo_pkg::rob_w-1:0]    rb_idx;
  logic [ooo_pkg::rob_w-1:0]    br_age;
  logic [ooo_pkg::rob_w-1:0]    age [ooo_pkg::num_rob];
  logic [ooo_pkg::num_rob-1:0]  younger;
  logic                         draining;

  assign rob_idx[0] = tail;
  assign rob_idx[1] = tail + 1'b1;
  assign ret_ptr[0] = head;
  assign ret_ptr[1] = head + 1'b1;

  // oldest valid mispredicted branch, lane 0 wins
  always_comb begin
    rb_en  = 1'b0;
    rb_idx = '0;
    for (int l = ooo_pkg::num_super - 1; l >= 0; l--) begin
      if (cdb[l].valid && cdb[l].mispredict && entries[cdb[l].rob_idx].valid) begin
        rb_en  = 1'b1;
        rb_idx = cdb[l].rob_idx;
      end
    end
  end

  // distance from head decides what is younger than the branch
  always_comb begin
    br_age = rb_idx - head;
    for (int i = 0; i < ooo_pkg::num_rob; i++) begin
      age[i]     = i[ooo_pkg::rob_w-1:0] - head;
      younger[i] = age[i] > br_age;
    end
  end

  always_comb begin
    retire_en[0] = entries[head].valid && entries[head].complete && !rb_en;
    // nothing after a halt or illegal leaves alongside it
    retire_en[1] = retire_en[0] && entries[ret_ptr[1]].valid
                   && entries[ret_ptr[1]].complete
                   && !entries[head].halt && !entries[head].illegal;
    n_retire   = '0;
    n_dispatch = '0;
    for (int l = 0; l < ooo_pkg::num_super; l++) begin
      n_retire   = n_retire + retire_en[l];
      n_dispatch = n_dispatch + dispatch_en;
      retire[l].valid      = retire_en[l];
      retire[l].dest       = entries[ret_ptr[l]].dest;
      retire[l].t_idx      = entries[ret_ptr[l]].t_idx;
      retire[l].told_idx   = entries[ret_ptr[l]].told_idx;
      retire[l].writes_reg = entries[ret_ptr[l]].writes_reg;
      retire[l].halt       = entries[ret_ptr[l]].halt;
      retire[l].illegal    = entries[ret_ptr[l]].illegal;
    end
  end

  assign rob_ready = !draining && !rb_en
                     && (count - n_retire <= ooo_pkg::num_rob - ooo_pkg::num_super);
  assign restore = draining && (count == '0);

  always_ff @(posedge clock) begin
    for (int l = 0; l < ooo_pkg::num_super; l++) begin
      if (cdb[l].valid && entries[cdb[l].rob_idx].valid) begin
        entries[cdb[l].rob_idx].complete <= 1'b1;
      end
    end
    for (int l = 0; l < ooo_pkg::num_super; l++) begin
      if (retire_en[l]) entries[ret_ptr[l]].valid <= 1'b0;
    end
    if (dispatch_en) begin
      for (int l = 0; l < ooo_pkg::num_super; l++) begin
        // halt and illegal never execute
        entries[rob_idx[l]] <= '{
          valid:      1'b1,
          complete:   dec[l].halt || dec[l].illegal,
          halt:       dec[l].halt,
          illegal:    dec[l].illegal,
          writes_reg: dec[l].writes_reg,
          dest:       ren[l].dest,
          t_idx:      ren[l].t_idx,
          told_idx:   ren[l].told_idx
        };
      end
    end
    if (rb_en) begin
      for (int i = 0; i < ooo_pkg::num_rob; i++) begin
        if (younger[i]) entries[i].valid <= 1'b0;
      end
    end
    if (reset) begin
      for (int i = 0; i < ooo_pkg::num_rob; i++) begin
        entries[i].valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      head     <= '0;
      tail     <= '0;
      count    <= '0;
      draining <= 1'b0;
      stopped  <= 1'b0;
    end else begin
      head <= head + n_retire[ooo_pkg::rob_w-1:0];
      if (rb_en) begin
        // no retire in this cycle, so head stays put
        tail     <= rb_idx + 1'b1;
        count    <= {1'b0, br_age} + 1'b1;
        draining <= 1'b1;
      end else begin
        tail  <= tail + n_dispatch[ooo_pkg::rob_w-1:0];
        count <= count + n_dispatch - n_retire;
      end
      if (restore) draining <= 1'b0;
      for (int l = 0; l < ooo_pkg::num_super; l++) begin
        if (dispatch_en && (dec[l].halt || dec[l].illegal)) stopped <= 1'b1;
      end
    end
  end

  a_dispatch_when_ready: assert property (@(posedge clock) disable iff (reset)
    dispatch_en |-> rob_ready && !stopped);

  a_count_bound: assert property (@(posedge clock) disable iff (reset)
    count <= ooo_pkg::num_rob);

endmodule

// ==== design/result_regfile.sv ====
module result_regfile (
  input  logic                                         clock,
  input  logic                                         reset,
  input  ooo_pkg::cdb_t        [ooo_pkg::num_super-1:0] cdb,
  input  ooo_pkg::retire_t     [ooo_pkg::num_super-1:0] retire,
  output ooo_pkg::retire_out_t [ooo_pkg::num_super-1:0] retire_out
);

  logic [ooo_pkg::data_w-1:0] regs [ooo_pkg::num_phys];

  always_ff @(posedge clock) begin
    if (reset) begin
      // initial architectural tags
      for (int i = 0; i < ooo_pkg::num_arch; i++) begin
        regs[i] <= '0;
      end
    end else begin
      for (int l = 0; l < ooo_pkg::num_super; l++) begin
        if (cdb[l].valid && cdb[l].writes_reg) regs[cdb[l].t_idx] <= cdb[l].value;
      end
    end
  end

  always_comb begin
    for (int l = 0; l < ooo_pkg::num_super; l++) begin
      retire_out[l].valid      = retire[l].valid;
      retire_out[l].dest       = retire[l].dest;
      retire_out[l].value      = retire[l].writes_reg ? regs[retire[l].t_idx] : '0;
      retire_out[l].writes_reg = retire[l].writes_reg;
      retire_out[l].halt       = retire[l].halt;
      retire_out[l].illegal    = retire[l].illegal;
    end
  end

endmodule

// ==== flist.f ====
design/ooo_pkg.sv
design/inst_decoder.sv
design/rename_unit.sv
design/execute_unit.sv
design/reorder_buffer.sv
design/result_regfile.sv
design/ooo_core.sv
tb/ooo_core_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module ooo_core_tb -o ooo_core_sim
./obj_dir/ooo_core_sim | tee sim.log
if grep -q "All tests passed" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

// ==== tb/ooo_core_tb.sv ====
module ooo_core_tb;

  localparam int random_pairs = 200;
  localparam int total_pairs = random_pairs + 20;

  typedef struct packed {
    logic [2:0] dest;
    logic [7:0] value;
    logic       writes_reg;
    logic       halt;
    logic       illegal;
    logic       miss;
  } model_t;

  logic                                               clock;
  logic                                               reset;
  logic                                               inst_valid;
  logic [ooo_pkg::num_super-1:0][ooo_pkg::inst_w-1:0] inst;
  logic                                               dispatch_ready;
  ooo_pkg::retire_out_t [ooo_pkg::num_super-1:0]      retire_out;

  model_t       model_q [$];
  model_t [1:0] exp_entry;
  logic   [1:0] exp_valid;
  logic         miss_live;
  int           miss_age;
  logic         stop_seen;
  logic         halted;
  logic [31:0]  lcg_state;
  int           mismatch_count;
  int           other_count;
  int           retired_count;

  ooo_core i_dut (
    .clock          (clock),
    .reset          (reset),
    .inst_valid     (inst_valid),
    .inst           (inst),
    .dispatch_ready (dispatch_ready),
    .retire_out     (retire_out)
  );

  always #5 clock = ~clock;

  function automatic logic [15:0] encode(input ooo_pkg::opcode_e op, input logic [2:0] dest,
                                         input logic [4:0] a, input logic [4:0] b);
    return {op, dest, a, b};
  endfunction

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // add, sub, xor or a correctly predicted branch
  function automatic logic [15:0] random_inst();
    logic [31:0] r;
    r = lcg_next();
    return encode(ooo_pkg::opcode_e'({1'b0, r[17:16]}), r[20:18], r[25:21], r[30:26]);
  endfunction

  // expected retire record from the opcode rule
  function automatic model_t model_entry(input logic [15:0] w);
    model_t     m;
    logic [7:0] a;
    logic [7:0] b;
    a = {3'b000, w[9:5]};
    b = {3'b000, w[4:0]};
    m = '0;
    m.dest = w[12:10];
    case (w[15:13])
      3'd0: m.value = a + b;
      3'd1: m.value = a - b;
      3'd2: m.value = a ^ b;
      default: m.value = 8'h00;
    endcase
    m.writes_reg = (w[15:13] <= 3'd2);
    m.miss       = (w[15:13] == 3'd4);
    m.halt       = (w[15:13] == 3'd5);
    m.illegal    = (w[15:13] >= 3'd6);
    return m;
  endfunction

  // retire pops, dispatch pushes
  always @(posedge clock) begin
    model_t ent;
    if (reset) begin
      model_q.delete();
      miss_live = 1'b0;
      miss_age  = 0;
      stop_seen = 1'b0;
      halted    = 1'b0;
    end else begin
      if (miss_live) miss_age++;
      for (int l = 0; l < 2; l++) begin
        if (retire_out[l].valid && model_q.size() > 0) begin
          ent = model_q.pop_front();
          retired_count++;
          if (ent.miss) miss_live = 1'b0;
          if (ent.halt || ent.illegal) halted = 1'b1;
        end
      end
      if (inst_valid && dispatch_ready) begin
        for (int l = 0; l < 2; l++) begin
          ent = model_entry(inst[l]);
          // anything behind an unresolved miss never retires
          if (!miss_live) begin
            model_q.push_back(ent);
            if (ent.miss) begin
              miss_live = 1'b1;
              miss_age  = 0;
            end
          end
          if (ent.halt || ent.illegal) stop_seen = 1'b1;
        end
      end
    end
    exp_valid[0] = model_q.size() > 0;
    exp_valid[1] = model_q.size() > 1;
    exp_entry[0] = exp_valid[0] ? model_q[0] : '0;
    exp_entry[1] = exp_valid[1] ? model_q[1] : '0;
  end

  for (genvar l = 0; l < 2; l++) begin : g_lane_chk
    a_retire_match: assert property (@(posedge clock) disable iff (reset)
      retire_out[l].valid |-> exp_valid[l]
        && retire_out[l].dest == exp_entry[l].dest
        && retire_out[l].value == exp_entry[l].value
        && retire_out[l].writes_reg == exp_entry[l].writes_reg
        && retire_out[l].halt == exp_entry[l].halt
        && retire_out[l].illegal == exp_entry[l].illegal)
      else begin
        mismatch_count++;
        $display("mismatch at %0t: lane %0d got dest %0d value %0h, expected dest %0d value %0h",
                 $time, l, $sampled(retire_out[l].dest), $sampled(retire_out[l].value),
                 $sampled(exp_entry[l].dest), $sampled(exp_entry[l].value));
      end
  end

  a_lane_order: assert property (@(posedge clock) disable iff (reset)
    retire_out[1].valid |-> retire_out[0].valid)
    else begin
      other_count++;
      $display("lane 1 retired without lane 0 at %0t", $time);
    end

  a_reset_state: assert property (@(posedge clock)
    $fell(reset) |-> !retire_out[0].valid && !retire_out[1].valid && dispatch_ready)
    else begin
      other_count++;
      $display("core not idle and ready right after reset at %0t", $time);
    end

  // resolved miss blocks dispatch until it retires
  a_drain_block: assert property (@(posedge clock) disable iff (reset)
    miss_live && miss_age >= 2 |-> !dispatch_ready)
    else begin
      other_count++;
      $display("dispatch ready during a mispredict drain at %0t", $time);
    end

  a_stop_block: assert property (@(posedge clock) disable iff (reset)
    stop_seen |-> !dispatch_ready)
    else begin
      other_count++;
      $display("dispatch ready after a halt or illegal instruction at %0t", $time);
    end

  a_quiet_after_halt: assert property (@(posedge clock) disable iff (reset)
    halted |-> !retire_out[0].valid && !retire_out[1].valid)
    else begin
      other_count++;
      $display("instruction retired after a halt or illegal instruction at %0t", $time);
    end

  task automatic apply_reset();
    #1;
    reset      = 1'b1;
    inst_valid = 1'b0;
    repeat (4) @(posedge clock);
    #1;
    reset = 1'b0;
    @(posedge clock);
  endtask

  task automatic send_pair(input logic [15:0] w0, input logic [15:0] w1);
    #1;
    inst_valid = 1'b1;
    inst[0]    = w0;
    inst[1]    = w1;
    @(posedge clock);
    while (!dispatch_ready) @(posedge clock);
  endtask

  task automatic wait_drain();
    #1;
    inst_valid = 1'b0;
    while (model_q.size() != 0) @(negedge clock);
    @(posedge clock);
  endtask

  // offer a pair that must not be taken
  task automatic hold_blocked(input int cycles);
    #1;
    inst_valid = 1'b1;
    inst[0]    = encode(ooo_pkg::op_add, 3'd1, 5'd1, 5'd1);
    inst[1]    = encode(ooo_pkg::op_add, 3'd2, 5'd2, 5'd2);
    repeat (cycles) @(posedge clock);
    #1;
    inst_valid = 1'b0;
    @(posedge clock);
  endtask

  initial begin
    repeat (40 * total_pairs + 200) @(posedge clock);
    $display("timeout: run did not finish within %0d cycles", 40 * total_pairs + 200);
    $display("Some tests failed");
    $finish;
  end

  initial begin
    clock          = 1'b0;
    reset          = 1'b1;
    inst_valid     = 1'b0;
    inst           = '0;
    lcg_state      = 32'h4714;
    mismatch_count = 0;
    other_count    = 0;
    retired_count  = 0;
    apply_reset();

    // arithmetic pairs including one with a shared destination
    send_pair(encode(ooo_pkg::op_add, 3'd1, 5'd3, 5'd4), encode(ooo_pkg::op_sub, 3'd2, 5'd3, 5'd7));
    send_pair(encode(ooo_pkg::op_xor, 3'd1, 5'd31, 5'd15),
              encode(ooo_pkg::op_add, 3'd1, 5'd31, 5'd31));
    send_pair(encode(ooo_pkg::op_sub, 3'd0, 5'd0, 5'd31), encode(ooo_pkg::op_xor, 3'd7, 5'd9, 5'd6));
    wait_drain();

    // miss in lane 1 with one pair in its shadow and two after the flush
    send_pair(encode(ooo_pkg::op_add, 3'd3, 5'd5, 5'd6),
              encode(ooo_pkg::op_branch_miss, 3'd0, 5'd0, 5'd0));
    send_pair(encode(ooo_pkg::op_add, 3'd3, 5'd1, 5'd1), encode(ooo_pkg::op_xor, 3'd4, 5'd9, 5'd9));
    send_pair(encode(ooo_pkg::op_sub, 3'd5, 5'd2, 5'd1), encode(ooo_pkg::op_add, 3'd6, 5'd8, 5'd8));
    send_pair(encode(ooo_pkg::op_add, 3'd3, 5'd10, 5'd11),
              encode(ooo_pkg::op_sub, 3'd4, 5'd20, 5'd2));
    // miss in lane 0 flushes its own lane 1
    send_pair(encode(ooo_pkg::op_branch_miss, 3'd0, 5'd0, 5'd0),
              encode(ooo_pkg::op_add, 3'd2, 5'd1, 5'd2));
    send_pair(encode(ooo_pkg::op_xor, 3'd2, 5'd3, 5'd3), encode(ooo_pkg::op_add, 3'd3, 5'd4, 5'd4));
    send_pair(encode(ooo_pkg::op_add, 3'd2, 5'd12, 5'd13),
              encode(ooo_pkg::op_branch, 3'd0, 5'd0, 5'd0));
    wait_drain();

    // long stream to recycle tags
    for (int i = 0; i < random_pairs; i++) begin
      send_pair(random_inst(), random_inst());
    end
    wait_drain();

    send_pair(encode(ooo_pkg::op_add, 3'd5, 5'd2, 5'd2),
              encode(ooo_pkg::op_halt, 3'd0, 5'd0, 5'd0));
    wait_drain();
    hold_blocked(10);

    apply_reset();
    send_pair(encode(ooo_pkg::op_xor, 3'd6, 5'd7, 5'd1), encode(ooo_pkg::op_add, 3'd7, 5'd1, 5'd2));
    send_pair(encode(ooo_pkg::op_sub, 3'd0, 5'd9, 5'd3),
              encode(ooo_pkg::op_illegal_a, 3'd0, 5'd0, 5'd0));
    wait_drain();
    hold_blocked(10);

    if (model_q.size() != 0) begin
      other_count++;
      $display("%0d instructions never retired", model_q.size());
    end
    $display("closing: %0d mismatches, %0d other errors, %0d instructions retired",
             mismatch_count, other_count, retired_count);
    if (mismatch_count == 0 && other_count == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule
